/* rv_decode_cases.txt */
# kind instr err rs1 rs2 bubble | exp rd uop fu trap opr_a opr_b opr_c (hex)
# kind 0 decodes instr, kind 1 redirects the PC to the instr column
0 002081B3 0 11111111 22222222 0 03 01 1 0 11111111 22222222 00000000
0 407302B3 0 00000010 00000003 0 05 02 1 0 00000010 00000003 00000000
0 00A4F433 0 F0F0F0F0 0FF00FF0 0 08 03 1 0 F0F0F0F0 0FF00FF0 00000000
0 403150B3 0 80000000 00000004 0 01 08 1 0 80000000 00000004 00000000
0 0062B233 0 00000001 00000002 0 04 07 1 0 00000001 00000002 00000000
0 FFF10093 0 00000005 00000009 0 01 01 1 0 00000005 FFFFFFFF 00000000
0 12344393 0 AAAA0000 00000000 0 07 05 1 0 AAAA0000 00000123 00000000
0 40755493 0 F0000000 00000000 0 09 08 1 0 F0000000 00000007 00000000
0 01F19113 0 00000001 00000000 0 02 0A 1 0 00000001 0000001F 00000000
0 123452B7 0 DEADBEEF 12345678 0 05 04 1 0 00000000 12345000 00000000
0 00001317 0 DEADBEEF 12345678 0 06 01 1 0 80001028 00000000 00000000
0 00208863 0 00000005 00000005 0 00 01 2 0 00000005 00000005 8000003C
0 FE419EE3 0 00000001 00000002 0 00 02 2 0 00000001 00000002 8000002C
0 0062F463 0 00000007 00000008 0 00 06 2 0 00000007 00000008 8000003C
0 001000EF 0 00000000 00000000 0 01 07 2 0 00000000 00000000 80000838
0 00408067 0 80001000 00000000 0 00 08 2 0 80001000 00000004 00000000
0 FF810503 0 00002000 00000000 0 0A 0B 4 0 00002000 FFFFFFF8 00000000
0 0061D583 0 00000100 00000000 0 0B 0C 4 0 00000100 00000006 00000000
0 00022603 0 00000040 00000000 0 0C 0F 4 0 00000040 00000000 00000000
0 00532623 0 00001000 CAFEBABE 0 00 16 4 0 00001000 0000000C CAFEBABE
0 FE740FA3 0 00000200 000000AB 0 00 12 4 0 00000200 FFFFFFFF 000000AB
0 00000073 0 12345678 87654321 0 00 09 2 0 00000000 00000000 00000000
0 00100073 0 12345678 87654321 0 00 0A 2 0 00000000 00000000 00000000
0 0000000F 0 12345678 87654321 0 02 00 0 1 00000000 00000000 00000000
0 023100B3 0 12345678 87654321 0 02 00 0 1 00000000 00000000 00000000
0 002081B3 1 00000003 00000004 0 01 01 1 1 00000003 00000004 00000000
0 FFFFFFFF 1 00000003 00000004 0 02 00 0 1 00000000 00000000 00000000
0 002081B3 0 55555555 66666666 1 00 00 0 0 00000000 00000000 00000000
0 00000097 0 00000000 00000000 0 01 01 1 0 8000006C 00000000 00000000
1 00010000 0 00000000 00000000 0 00 00 0 0 00000000 00000000 00000000
0 00002117 0 00000000 00000000 0 02 01 1 0 00012000 00000000 00000000
0 00000197 0 00000000 00000000 0 03 01 1 0 00010004 00000000 00000000

/* rv_decode_top.f */
rv_decode_pkg.sv
rv_decode_ctrl.sv
rv_imm_gen.sv
rv_pc_track.sv
rv_operand_mux.sv
rv_stage_reg.sv
rv_decode_top.sv
tb_rv_decode_sva.sv
tb_rv_decode.sv

/* Makefile */
.PHONY: build run clean

build:
	verilator --binary --timing --assert -f rv_decode_top.f --top-module tb_rv_decode -o Vtb_rv_decode

run: build
	./obj_dir/Vtb_rv_decode

clean:
	rm -rf obj_dir

/* tb_rv_decode.sv */
`default_nettype none

module tb_rv_decode;

    timeunit 1ns;
    timeprecision 1ps;

    // Columns of one case line
    localparam int col_kind  = 0;     // 0 decode, 1 redirect
    localparam int col_instr = 1;     // Instruction or redirect target
    localparam int col_err   = 2;
    localparam int col_rs1   = 3;
    localparam int col_rs2   = 4;
    localparam int col_bub   = 5;
    localparam int col_rd    = 6;
    localparam int col_uop   = 7;
    localparam int col_fu    = 8;
    localparam int col_trap  = 9;
    localparam int col_a     = 10;
    localparam int col_b     = 11;
    localparam int col_c     = 12;
    localparam int max_cases = 64;

    logic        g_clk;
    logic        g_resetn;
    logic        s1_valid_i;
    logic        s1_busy_o;
    logic [31:0] s1_data_i;
    logic        s1_error_i;
    logic        s1_flush_i;
    logic        s1_bubble_i;
    logic [4:0]  s1_rs1_addr_o;
    logic [4:0]  s1_rs2_addr_o;
    logic [31:0] s1_rs1_rdata_i;
    logic [31:0] s1_rs2_rdata_i;
    logic        cf_req_i;
    logic [31:0] cf_target_i;
    logic        cf_ack_i;
    logic        s2_valid_o;
    logic        s2_busy_i;
    logic [4:0]  s2_rd_o;
    logic [31:0] s2_opr_a_o;
    logic [31:0] s2_opr_b_o;
    logic [31:0] s2_opr_c_o;
    logic [4:0]  s2_uop_o;
    logic [2:0]  s2_fu_o;
    logic        s2_trap_o;

    logic [31:0] cases_mem [max_cases][13];
    int          n_cases   = 0;
    int          exp_q [$];           // Case indices in flight

    rv_decode_top rv_decode_top_i (.*);

    initial g_clk = 1'b0;
    always #50 g_clk = !g_clk;

    // Random stall from stage 2
    initial begin : stall_gen
        void'($urandom(8367));
        s2_busy_i = 1'b0;
        forever begin
            @(posedge g_clk);
            #5;
            s2_busy_i = ($urandom % 10) < 3;
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR: %0t ns, field %s got %h expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Output checker, entry is taken at the next rising edge
    // ------------------------------------------------------------
    always @(negedge g_clk) begin : check_outputs
        int idx;
        if (g_resetn && s2_valid_o && !s2_busy_i) begin
            assert (exp_q.size() > 0) else begin
                $display("Stage 2 showed an entry at %0t ns that was never sent", $time);
                $display("Something failed");
                $fatal(1, "Extra entry");
            end
            idx = exp_q.pop_front();
            check_field("rd",   {27'b0, s2_rd_o},   cases_mem[idx][col_rd]);
            check_field("uop",  {27'b0, s2_uop_o},  cases_mem[idx][col_uop]);
            check_field("fu",   {29'b0, s2_fu_o},   cases_mem[idx][col_fu]);
            check_field("trap", {31'b0, s2_trap_o}, cases_mem[idx][col_trap]);
            check_field("opr_a", s2_opr_a_o, cases_mem[idx][col_a]);
            check_field("opr_b", s2_opr_b_o, cases_mem[idx][col_b]);
            check_field("opr_c", s2_opr_c_o, cases_mem[idx][col_c]);
        end
    end

    initial begin : watchdog
        wait (g_resetn === 1'b1);
        #(n_cases * 20 * 100);
        $display("Timeout, the run did not finish in %0d cycles", n_cases * 20);
        $display("Something failed");
        $fatal(1, "Timeout");
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        int    fd;
        int    rc;
        string line;
        logic  bub;
        g_resetn       = 1'b0;
        s1_valid_i     = 1'b0;
        s1_data_i      = '0;
        s1_error_i     = 1'b0;
        s1_flush_i     = 1'b0;
        s1_bubble_i    = 1'b0;
        s1_rs1_rdata_i = '0;
        s1_rs2_rdata_i = '0;
        cf_req_i       = 1'b0;
        cf_ack_i       = 1'b0;
        cf_target_i    = '0;

        fd = $fopen("rv_decode_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open rv_decode_cases.txt");
            $display("Something failed");
            $fatal(1, "No case file");
        end
        while (!$feof(fd) && n_cases < max_cases) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line[0] != "#") begin
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                             cases_mem[n_cases][0], cases_mem[n_cases][1],
                             cases_mem[n_cases][2], cases_mem[n_cases][3],
                             cases_mem[n_cases][4], cases_mem[n_cases][5],
                             cases_mem[n_cases][6], cases_mem[n_cases][7],
                             cases_mem[n_cases][8], cases_mem[n_cases][9],
                             cases_mem[n_cases][10], cases_mem[n_cases][11],
                             cases_mem[n_cases][12]);
                if (rc == 13) begin
                    n_cases++;
                end
            end
        end
        $fclose(fd);

        repeat (3) @(posedge g_clk);
        #5;
        g_resetn = 1'b1;

        for (int i = 0; i < n_cases; i++) begin
            if (cases_mem[i][col_kind] == 1) begin
                cf_target_i = cases_mem[i][col_instr];
                cf_req_i    = 1'b1;
                cf_ack_i    = 1'b1;
                @(posedge g_clk);
                #5;
                cf_req_i    = 1'b0;
                cf_ack_i    = 1'b0;
            end else begin
                bub            = cases_mem[i][col_bub][0];
                s1_data_i      = cases_mem[i][col_instr];
                s1_error_i     = cases_mem[i][col_err][0];
                s1_rs1_rdata_i = cases_mem[i][col_rs1];
                s1_rs2_rdata_i = cases_mem[i][col_rs2];
                s1_bubble_i    = bub;
                s1_valid_i     = !bub;
                @(negedge g_clk);
                // A bubble waits only for the held entry to drain
                while (bub ? (s2_valid_o && s2_busy_i) : s1_busy_o) @(negedge g_clk);
                // Register file read ports, rs1 in bits 19:15 and rs2 in bits 24:20
                check_field("rs1_addr", {27'b0, s1_rs1_addr_o},
                            {27'b0, cases_mem[i][col_instr][19:15]});
                check_field("rs2_addr", {27'b0, s1_rs2_addr_o},
                            {27'b0, cases_mem[i][col_instr][24:20]});
                @(posedge g_clk);
                exp_q.push_back(i);
                #5;
                s1_valid_i  = 1'b0;
                s1_bubble_i = 1'b0;
            end
        end

        while (exp_q.size() != 0) @(negedge g_clk);
        @(negedge g_clk);
        if (!s2_valid_o) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Stage 2 still held an entry after the last case was taken");
            $display("Something failed");
            $fatal(1, "Extra entry");
        end
    end

endmodule

`default_nettype wire

/* tb_rv_decode_sva.sv */
`default_nettype none

module tb_rv_decode_sva (
    input wire        g_clk,
    input wire        g_resetn,
    input wire        flush_i,
    input wire        busy_i,
    input wire        valid_o,
    input wire [4:0]  rd_o,
    input wire [31:0] opr_a_o,
    input wire [31:0] opr_b_o,
    input wire [31:0] opr_c_o,
    input wire [4:0]  uop_o,
    input wire [2:0]  fu_o,
    input wire        trap_o
);

    timeunit 1ns;
    timeprecision 1ps;

    reset_clears_valid: assert property (@(posedge g_clk) !g_resetn |=> !valid_o)
        else $error("valid set after reset");

    // Held entry must not move under stall
    hold_is_stable: assert property (@(posedge g_clk)
        (g_resetn && valid_o && busy_i && !flush_i) |=>
        (valid_o && $stable({rd_o, opr_a_o, opr_b_o, opr_c_o, uop_o, fu_o, trap_o})))
        else $error("entry changed while stalled");

    trap_cause_valid: assert property (@(posedge g_clk)
        (g_resetn && valid_o && trap_o) |-> (rd_o == 5'd1 || rd_o == 5'd2))
        else $error("trap with bad cause in rd");

endmodule

bind rv_stage_reg tb_rv_decode_sva tb_rv_decode_sva_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .flush_i  (flush_i),
    .busy_i   (busy_i),
    .valid_o  (valid_o),
    .rd_o     (rd_o),
    .opr_a_o  (opr_a_o),
    .opr_b_o  (opr_b_o),
    .opr_c_o  (opr_c_o),
    .uop_o    (uop_o),
    .fu_o     (fu_o),
    .trap_o   (trap_o)
);

`default_nettype wire

/* rv_decode_top.sv */
`default_nettype none

module rv_decode_top import rv_decode_pkg::*; (
    input  wire        g_clk,
    input  wire        g_resetn,

    input  wire        s1_valid_i,
    output logic       s1_busy_o,
    input  wire word_t s1_data_i,
    input  wire        s1_error_i,
    input  wire        s1_flush_i,
    input  wire        s1_bubble_i,
    output reg_addr_t  s1_rs1_addr_o,
    output reg_addr_t  s1_rs2_addr_o,
    input  wire word_t s1_rs1_rdata_i,
    input  wire word_t s1_rs2_rdata_i,

    input  wire        cf_req_i,       // Control flow change request
    input  wire word_t cf_target_i,
    input  wire        cf_ack_i,

    output logic       s2_valid_o,
    input  wire        s2_busy_i,
    output reg_addr_t  s2_rd_o,        // Dest reg or trap cause
    output word_t      s2_opr_a_o,
    output word_t      s2_opr_b_o,
    output word_t      s2_opr_c_o,
    output uop_t       s2_uop_o,
    output fu_t        s2_fu_o,
    output logic       s2_trap_o
);

    reg_addr_t n_rd;
    uop_t      n_uop;
    fu_t       n_fu;
    logic      n_trap;
    imm_fmt_t  imm_fmt;
    opa_sel_t  opa_sel;
    opb_sel_t  opb_sel;
    opc_sel_t  opc_sel;
    word_t     imm;
    word_t     pc_imm;          // PC plus immediate
    word_t     n_opr_a;
    word_t     n_opr_b;
    word_t     n_opr_c;
    logic      accept;

    rv_decode_ctrl rv_decode_ctrl_i (
        .instr_i    (s1_data_i),
        .error_i    (s1_error_i),
        .rs1_addr_o (s1_rs1_addr_o),
        .rs2_addr_o (s1_rs2_addr_o),
        .rd_o       (n_rd),
        .uop_o      (n_uop),
        .fu_o       (n_fu),
        .trap_o     (n_trap),
        .imm_fmt_o  (imm_fmt),
        .opa_sel_o  (opa_sel),
        .opb_sel_o  (opb_sel),
        .opc_sel_o  (opc_sel)
    );

    rv_imm_gen rv_imm_gen_i (
        .instr_i   (s1_data_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    rv_pc_track rv_pc_track_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .accept_i    (accept),
        .cf_req_i    (cf_req_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .imm_i       (imm),
        .pc_imm_o    (pc_imm)
    );

    rv_operand_mux rv_operand_mux_i (
        .opa_sel_i   (opa_sel),
        .opb_sel_i   (opb_sel),
        .opc_sel_i   (opc_sel),
        .rs1_rdata_i (s1_rs1_rdata_i),
        .rs2_rdata_i (s1_rs2_rdata_i),
        .imm_i       (imm),
        .pc_imm_i    (pc_imm),
        .opr_a_o     (n_opr_a),
        .opr_b_o     (n_opr_b),
        .opr_c_o     (n_opr_c)
    );

    rv_stage_reg rv_stage_reg_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .valid_i  (s1_valid_i),
        .bubble_i (s1_bubble_i),
        .flush_i  (s1_flush_i),
        .busy_i   (s2_busy_i),
        .rd_i     (n_rd),
        .opr_a_i  (n_opr_a),
        .opr_b_i  (n_opr_b),
        .opr_c_i  (n_opr_c),
        .uop_i    (n_uop),
        .fu_i     (n_fu),
        .trap_i   (n_trap),
        .busy_o   (s1_busy_o),
        .accept_o (accept),
        .valid_o  (s2_valid_o),
        .rd_o     (s2_rd_o),
        .opr_a_o  (s2_opr_a_o),
        .opr_b_o  (s2_opr_b_o),
        .opr_c_o  (s2_opr_c_o),
        .uop_o    (s2_uop_o),
        .fu_o     (s2_fu_o),
        .trap_o   (s2_trap_o)
    );

endmodule

`default_nettype wire

/* rv_stage_reg.sv */
`default_nettype none

module rv_stage_reg import rv_decode_pkg::*; (
    input  wire            g_clk,
    input  wire            g_resetn,
    input  wire            valid_i,
    input  wire            bubble_i,    // Load an all-zero entry
    input  wire            flush_i,
    input  wire            busy_i,      // Stage 2 stalled
    input  wire reg_addr_t rd_i,
    input  wire word_t     opr_a_i,
    input  wire word_t     opr_b_i,
    input  wire word_t     opr_c_i,
    input  wire uop_t      uop_i,
    input  wire fu_t       fu_i,
    input  wire            trap_i,
    output logic           busy_o,
    output logic           accept_o,
    output logic           valid_o,
    output reg_addr_t      rd_o,
    output word_t          opr_a_o,
    output word_t          opr_b_o,
    output word_t          opr_c_o,
    output uop_t           uop_o,
    output fu_t            fu_o,
    output logic           trap_o
);

    logic hold;   // Entry waiting on stage 2
    logic load;

    assign hold     = valid_o && busy_i;
    assign busy_o   = hold || bubble_i;
    assign accept_o = valid_i && !busy_o;
    assign load     = accept_o || (bubble_i && !hold);

    // ------------------------------------------------------------
    // Valid flag, flush beats load
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush_i) begin
            valid_o <= 1'b0;
        end else if (!hold) begin
            valid_o <= load;
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            if (bubble_i) begin
                rd_o    <= '0;
                opr_a_o <= '0;
                opr_b_o <= '0;
                opr_c_o <= '0;
                uop_o   <= '0;
                fu_o    <= '0;
                trap_o  <= 1'b0;
            end else begin
                rd_o    <= rd_i;
                opr_a_o <= opr_a_i;
                opr_b_o <= opr_b_i;
                opr_c_o <= opr_c_i;
                uop_o   <= uop_i;
                fu_o    <= fu_i;
                trap_o  <= trap_i;
            end
        end
    end

endmodule

`default_nettype wire

/* rv_operand_mux.sv */
`default_nettype none

module rv_operand_mux import rv_decode_pkg::*; (
    input  wire opa_sel_t opa_sel_i,
    input  wire opb_sel_t opb_sel_i,
    input  wire opc_sel_t opc_sel_i,
    input  wire word_t    rs1_rdata_i,
    input  wire word_t    rs2_rdata_i,
    input  wire word_t    imm_i,
    input  wire word_t    pc_imm_i,
    output word_t         opr_a_o,
    output word_t         opr_b_o,
    output word_t         opr_c_o
);

    always_comb begin
        case (opa_sel_i)
            opa_rs1:  opr_a_o = rs1_rdata_i;
            opa_pcim: opr_a_o = pc_imm_i;
            default:  opr_a_o = '0;
        endcase
    end

    always_comb begin
        case (opb_sel_i)
            opb_rs2: opr_b_o = rs2_rdata_i;
            opb_imm: opr_b_o = imm_i;
            default: opr_b_o = '0;
        endcase
    end

    // Store data or branch target
    always_comb begin
        case (opc_sel_i)
            opc_rs2:  opr_c_o = rs2_rdata_i;
            opc_pcim: opr_c_o = pc_imm_i;
            default:  opr_c_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rv_pc_track.sv */
`default_nettype none

module rv_pc_track import rv_decode_pkg::*; (
    input  wire        g_clk,
    input  wire        g_resetn,
    input  wire        accept_i,      // Stage 1 instruction taken
    input  wire        cf_req_i,
    input  wire        cf_ack_i,
    input  wire word_t cf_target_i,
    input  wire word_t imm_i,
    output word_t      pc_imm_o
);

    word_t pc_q;   // PC of the word now in stage 1

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= pc_reset_value;
        end else if (cf_req_i && cf_ack_i) begin
            pc_q <= cf_target_i;           // Redirect beats advance
        end else if (accept_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // For auipc, branch and jal targets
    assign pc_imm_o = pc_q + imm_i;

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
    input  wire word_t      instr_i,
    input  wire imm_fmt_t   imm_fmt_i,
    output word_t           imm_o
);

    always_comb begin
        case (imm_fmt_i)
            imm_i: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            imm_s: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            imm_b: begin
                imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            imm_u: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            imm_j: begin
                imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            imm_shamt: begin
                imm_o = {27'b0, instr_i[24:20]};   // Zero extended
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv_decode_ctrl.sv */
`default_nettype none

module rv_decode_ctrl import rv_decode_pkg::*; (
    input  wire word_t instr_i,
    input  wire        error_i,     // Fetch error on this word
    output reg_addr_t  rs1_addr_o,
    output reg_addr_t  rs2_addr_o,
    output reg_addr_t  rd_o,
    output uop_t       uop_o,
    output fu_t        fu_o,
    output logic       trap_o,
    output imm_fmt_t   imm_fmt_o,
    output opa_sel_t   opa_sel_o,
    output opb_sel_t   opb_sel_o,
    output opc_sel_t   opc_sel_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       f7_zero;
    logic       f7_alt;       // 0100000, sub and sra
    logic       reg_ok;
    logic       imm_ok;
    logic       is_shift;     // slli, srli, srai
    logic       legal;
    logic       no_rd;        // Stores, branches, ecall, ebreak
    uop_t       alu_uop;
    logic [1:0] lsu_width;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign f7_zero = instr_i[31:25] == 7'b0000000;
    assign f7_alt  = instr_i[31:25] == 7'b0100000;

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign is_shift = funct3[1:0] == 2'b01;
    assign reg_ok   = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign imm_ok   = !is_shift || f7_zero || (f7_alt && funct3 == 3'b101);

    // ------------------------------------------------------------
    // ALU op and access width from funct3
    // ------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  alu_uop = (opcode == op_reg && instr_i[30]) ? alu_sub : alu_add;
            3'b001:  alu_uop = alu_sll;
            3'b010:  alu_uop = alu_slt;
            3'b011:  alu_uop = alu_sltu;
            3'b100:  alu_uop = alu_xor;
            3'b101:  alu_uop = instr_i[30] ? alu_sra : alu_srl;
            3'b110:  alu_uop = alu_or;
            default: alu_uop = alu_and;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   lsu_width = lsu_byte;
            2'b01:   lsu_width = lsu_half;
            default: lsu_width = lsu_word;
        endcase
    end

    // ------------------------------------------------------------
    // Instruction recognition
    // ------------------------------------------------------------
    always_comb begin
        legal     = 1'b0;
        no_rd     = 1'b0;
        fu_o      = '0;
        uop_o     = '0;
        imm_fmt_o = imm_none;
        opa_sel_o = opa_zero;
        opb_sel_o = opb_zero;
        opc_sel_o = opc_zero;
        case (opcode)
            op_reg: if (reg_ok) begin
                legal        = 1'b1;
                fu_o[fu_alu] = 1'b1;
                uop_o        = alu_uop;
                opa_sel_o    = opa_rs1;
                opb_sel_o    = opb_rs2;
            end
            op_imm: if (imm_ok) begin
                legal        = 1'b1;
                fu_o[fu_alu] = 1'b1;
                uop_o        = alu_uop;
                imm_fmt_o    = is_shift ? imm_shamt : imm_i;
                opa_sel_o    = opa_rs1;
                opb_sel_o    = opb_imm;
            end
            op_lui: begin
                legal        = 1'b1;
                fu_o[fu_alu] = 1'b1;
                uop_o        = alu_or;      // 0 | imm
                imm_fmt_o    = imm_u;
                opb_sel_o    = opb_imm;
            end
            op_auipc: begin
                legal        = 1'b1;
                fu_o[fu_alu] = 1'b1;
                uop_o        = alu_add;     // pcim + 0
                imm_fmt_o    = imm_u;
                opa_sel_o    = opa_pcim;
            end
            op_branch: if (funct3[2:1] != 2'b01) begin
                legal        = 1'b1;
                no_rd        = 1'b1;
                fu_o[fu_cfu] = 1'b1;
                case (funct3)
                    3'b000:  uop_o = cfu_beq;
                    3'b001:  uop_o = cfu_bne;
                    3'b100:  uop_o = cfu_blt;
                    3'b101:  uop_o = cfu_bge;
                    3'b110:  uop_o = cfu_bltu;
                    default: uop_o = cfu_bgeu;
                endcase
                imm_fmt_o    = imm_b;
                opa_sel_o    = opa_rs1;
                opb_sel_o    = opb_rs2;
                opc_sel_o    = opc_pcim;    // Taken target
            end
            op_jal: begin
                legal        = 1'b1;
                fu_o[fu_cfu] = 1'b1;
                uop_o        = cfu_jali;
                imm_fmt_o    = imm_j;
                opc_sel_o    = opc_pcim;
            end
            op_jalr: if (funct3 == 3'b000) begin
                legal        = 1'b1;
                fu_o[fu_cfu] = 1'b1;
                uop_o        = cfu_jalr;
                imm_fmt_o    = imm_i;
                opa_sel_o    = opa_rs1;
                opb_sel_o    = opb_imm;
            end
            op_load: if (funct3[1:0] != 2'b11 && funct3[2:1] != 2'b11) begin
                legal             = 1'b1;
                fu_o[fu_lsu]      = 1'b1;
                uop_o[lsu_load]   = 1'b1;
                uop_o[lsu_signed] = !funct3[2];   // lb, lh
                uop_o[2:1]        = lsu_width;
                imm_fmt_o         = imm_i;
                opa_sel_o         = opa_rs1;
                opb_sel_o         = opb_imm;
            end
            op_store: if (!funct3[2] && funct3[1:0] != 2'b11) begin
                legal            = 1'b1;
                no_rd            = 1'b1;
                fu_o[fu_lsu]     = 1'b1;
                uop_o[lsu_store] = 1'b1;
                uop_o[2:1]       = lsu_width;
                imm_fmt_o        = imm_s;
                opa_sel_o        = opa_rs1;
                opb_sel_o        = opb_imm;
                opc_sel_o        = opc_rs2;     // Store data
            end
            op_system: if (instr_i == instr_ecall || instr_i == instr_ebreak) begin
                legal        = 1'b1;
                no_rd        = 1'b1;
                fu_o[fu_cfu] = 1'b1;
                uop_o        = instr_i[20] ? cfu_ebreak : cfu_ecall;
            end
            default: ;
        endcase
    end

    // Trap cause replaces rd, opcode fault first
    assign trap_o = error_i || !legal;
    assign rd_o   = !legal  ? trap_iopcode :
                    error_i ? trap_iaccess :
                    no_rd   ? '0           : instr_i[11:7];

endmodule

`default_nettype wire

/* rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // ------------------------------------------------------------
    // Widths and base types
    // ------------------------------------------------------------
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;      // Instr, data, operands, PC
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      uop_t;
    typedef logic [2:0]      fu_t;        // One-hot unit select
    typedef logic [2:0]      imm_fmt_t;
    typedef logic [1:0]      opa_sel_t;
    typedef logic [1:0]      opb_sel_t;
    typedef logic [1:0]      opc_sel_t;

    // ------------------------------------------------------------
    // Micro-op codes, one set per unit
    // ------------------------------------------------------------
    localparam uop_t alu_add    = 5'd1;
    localparam uop_t alu_sub    = 5'd2;
    localparam uop_t alu_and    = 5'd3;
    localparam uop_t alu_or     = 5'd4;
    localparam uop_t alu_xor    = 5'd5;
    localparam uop_t alu_slt    = 5'd6;
    localparam uop_t alu_sltu   = 5'd7;
    localparam uop_t alu_sra    = 5'd8;
    localparam uop_t alu_srl    = 5'd9;
    localparam uop_t alu_sll    = 5'd10;

    localparam uop_t cfu_beq    = 5'd1;
    localparam uop_t cfu_bne    = 5'd2;
    localparam uop_t cfu_blt    = 5'd3;
    localparam uop_t cfu_bge    = 5'd4;
    localparam uop_t cfu_bltu   = 5'd5;
    localparam uop_t cfu_bgeu   = 5'd6;
    localparam uop_t cfu_jali   = 5'd7;
    localparam uop_t cfu_jalr   = 5'd8;
    localparam uop_t cfu_ecall  = 5'd9;
    localparam uop_t cfu_ebreak = 5'd10;

    // LSU uop is a bit field, width sits in bits 2:1
    localparam int lsu_signed = 0;
    localparam int lsu_load   = 3;
    localparam int lsu_store  = 4;
    localparam logic [1:0] lsu_byte = 2'b01;
    localparam logic [1:0] lsu_half = 2'b10;
    localparam logic [1:0] lsu_word = 2'b11;

    // Unit positions in fu_t
    localparam int fu_alu = 0;
    localparam int fu_cfu = 1;
    localparam int fu_lsu = 2;

    // ------------------------------------------------------------
    // Immediate formats and operand selects
    // ------------------------------------------------------------
    localparam imm_fmt_t imm_none  = 3'd0;
    localparam imm_fmt_t imm_i     = 3'd1;
    localparam imm_fmt_t imm_s     = 3'd2;
    localparam imm_fmt_t imm_b     = 3'd3;
    localparam imm_fmt_t imm_u     = 3'd4;
    localparam imm_fmt_t imm_j     = 3'd5;
    localparam imm_fmt_t imm_shamt = 3'd6;

    localparam opa_sel_t opa_zero = 2'd0;
    localparam opa_sel_t opa_rs1  = 2'd1;
    localparam opa_sel_t opa_pcim = 2'd2;
    localparam opb_sel_t opb_zero = 2'd0;
    localparam opb_sel_t opb_rs2  = 2'd1;
    localparam opb_sel_t opb_imm  = 2'd2;
    localparam opc_sel_t opc_zero = 2'd0;
    localparam opc_sel_t opc_rs2  = 2'd1;
    localparam opc_sel_t opc_pcim = 2'd2;

    // Trap causes travel in the rd field
    localparam reg_addr_t trap_iaccess = 5'd1;   // Fetch error
    localparam reg_addr_t trap_iopcode = 5'd2;   // Invalid instruction

    localparam word_t pc_reset_value = 32'h8000_0000;

    // ------------------------------------------------------------
    // RV32I major opcodes
    // ------------------------------------------------------------
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam word_t instr_ecall  = 32'h0000_0073;
    localparam word_t instr_ebreak = 32'h0010_0073;

endpackage

`default_nettype wire
